//--- src/pipeCpuPkg.sv
`default_nettype none

package pipeCpuPkg;

	// Datapath and register number widths
	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;

	// EX operand source select
	typedef logic [1:0] fwdSelT;
	localparam fwdSelT fwdRegFile = 2'd0;
	localparam fwdSelT fwdMemWb = 2'd1;
	localparam fwdSelT fwdExMem = 2'd2;

	// Opcode field values
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	// Function field values for R-type
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;

	// ID/EX record, loads keep their destination in rt
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memToReg;
		logic memWrite;
		logic aluSub;
		logic aluImm;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
	} idExT;

	// EX/MEM record
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		wordT aluOut;
		wordT storeVal;
	} exMemT;

	// MEM/WB record
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		regAddrT rt;
		regAddrT rd;
		wordT result;
	} memWbT;

	// Source registers seen in ID
	typedef struct packed {
		regAddrT rs;
		regAddrT rt;
		logic branch;
	} idHazT;

	// Hazard unit decisions
	typedef struct packed {
		fwdSelT forwardA;
		fwdSelT forwardB;
		logic memToMem;
		logic forwardC;
		logic forwardD;
		logic [1:0] writeToRead;
		logic stall;
	} fwdCtrlT;

endpackage

`default_nettype wire

//--- src/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
	input pipeCpuPkg::idHazT idHaz,
	input pipeCpuPkg::idExT idEx,
	input pipeCpuPkg::exMemT exMem,
	input pipeCpuPkg::memWbT memWb,
	output pipeCpuPkg::fwdCtrlT fwd
);
	import pipeCpuPkg::*;

	// ALU result in EX/MEM headed for a real register
	logic exAluHit;
	// ALU result in MEM/WB, matched on rd
	logic wbAluHit;
	// Load result in MEM/WB, matched on rt
	logic wbLoadHit;
	logic loadUse;
	logic branchUse;

	assign exAluHit = exMem.regWrite && (exMem.rd != '0);
	assign wbAluHit = memWb.regWrite && !memWb.memToReg && (memWb.rd != '0);
	assign wbLoadHit = memWb.memToReg && (memWb.rt != '0);

	// EX/MEM first, then MEM/WB, else the register value
	function automatic fwdSelT exSource(input regAddrT src, input exMemT em, input memWbT mw);
		logic emMatch;
		logic aluMatch;
		logic loadMatch;
		emMatch = em.regWrite && (em.rd != '0) && (em.rd == src);
		aluMatch = mw.regWrite && !mw.memToReg && (mw.rd != '0) && (mw.rd == src);
		// Any consumer in EX may take the load, stores included
		loadMatch = mw.memToReg && (mw.rt != '0) && (mw.rt == src);
		if (emMatch) begin
			return fwdExMem;
		end else if (aluMatch || loadMatch) begin
			return fwdMemWb;
		end
		return fwdRegFile;
	endfunction

	// Load in EX feeding the instruction in ID
	assign loadUse = idEx.memRead && ((idEx.rt == idHaz.rs) || (idEx.rt == idHaz.rt));
	// Branch operand still being computed in EX
	assign branchUse = idHaz.branch && idEx.regWrite && !idEx.memToReg &&
		((idEx.rd == idHaz.rs) || (idEx.rd == idHaz.rt));

	always_comb begin
		fwd.forwardA = exSource(idEx.rs, exMem, memWb);
		fwd.forwardB = exSource(idEx.rt, exMem, memWb);
		// Store in MEM right behind a load of its data register
		fwd.memToMem = (exMem.rt == memWb.rt) && memWb.memToReg && exMem.memWrite;
		// Branch compare from EX/MEM
		fwd.forwardC = idHaz.branch && exAluHit && (exMem.rd == idHaz.rs);
		fwd.forwardD = idHaz.branch && exAluHit && (exMem.rd == idHaz.rt);
		// WB result read in the same cycle, bit 0 for rs and bit 1 for rt
		fwd.writeToRead[0] = (wbLoadHit && (memWb.rt == idHaz.rs)) ||
			(wbAluHit && (memWb.rd == idHaz.rs));
		fwd.writeToRead[1] = (wbLoadHit && (memWb.rt == idHaz.rt)) ||
			(wbAluHit && (memWb.rd == idHaz.rt));
		// Hold PC and IF/ID, bubble into ID/EX
		fwd.stall = loadUse || branchUse;
	end

endmodule

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input logic clk,
	input logic reset,
	input pipeCpuPkg::regAddrT rdAddrA,
	input pipeCpuPkg::regAddrT rdAddrB,
	output pipeCpuPkg::wordT rdDataA,
	output pipeCpuPkg::wordT rdDataB,
	input logic wrEn,
	input pipeCpuPkg::regAddrT wrAddr,
	input pipeCpuPkg::wordT wrData
);
	import pipeCpuPkg::*;

	wordT regs [32];

	// Writes to r0 dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous reads
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

//--- src/fetchDecode.sv
`timescale 1ns/100ps
`default_nettype none

module fetchDecode #(
	parameter int imemWords = 64
) (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input logic [$clog2(imemWords)-1:0] progAddr,
	input pipeCpuPkg::wordT progData,
	input pipeCpuPkg::fwdCtrlT fwd,
	input pipeCpuPkg::exMemT exMem,
	input pipeCpuPkg::memWbT memWb,
	output pipeCpuPkg::idHazT idHaz,
	output pipeCpuPkg::idExT idEx,
	output pipeCpuPkg::regAddrT rdAddrA,
	output pipeCpuPkg::regAddrT rdAddrB,
	input pipeCpuPkg::wordT rdDataA,
	input pipeCpuPkg::wordT rdDataB
);
	import pipeCpuPkg::*;

	localparam int iIdxW = $clog2(imemWords);

	// Byte-addressed PC, word-addressed memory
	wordT pc;
	wordT pcPlus4;
	wordT imem [imemWords];
	// IF/ID
	wordT ifIdInstr;
	wordT ifIdPcNext;
	logic ifIdValid;
	// Decode fields
	logic [5:0] opcode;
	logic [5:0] funct;
	wordT immExt;
	wordT target;
	// Store whose data register is loaded by the instruction in EX
	logic storeAfterLoad;
	// Operands after WB bypass, then after EX/MEM forward for the compare
	wordT idRsVal;
	wordT idRtVal;
	wordT brA;
	wordT brB;
	logic taken;
	idExT dec;

	// Program port, open during reset
	always_ff @(posedge clk) begin
		if (progWrite) begin
			imem[progAddr] <= progData;
		end
	end

	assign pcPlus4 = pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (taken) begin
			pc <= target;
		end else if (!fwd.stall) begin
			pc <= pcPlus4;
		end
	end

	// Taken branch squashes the slot behind it
	always_ff @(posedge clk) begin
		if (reset || taken) begin
			ifIdValid <= 1'b0;
		end else if (!fwd.stall) begin
			ifIdValid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!fwd.stall && !taken) begin
			ifIdInstr <= imem[pc[iIdxW+1:2]];
			ifIdPcNext <= pcPlus4;
		end
	end

	assign opcode = ifIdInstr[31:26];
	assign funct = ifIdInstr[5:0];
	assign immExt = {{16{ifIdInstr[15]}}, ifIdInstr[15:0]};
	assign target = ifIdPcNext + (immExt << 2);
	assign rdAddrA = ifIdInstr[25:21];
	assign rdAddrB = ifIdInstr[20:16];

	// Loaded word reaches the store in MEM, so no stall on its data register
	assign storeAfterLoad = ifIdValid && (opcode == opSw) && idEx.memRead &&
		(idEx.rt == ifIdInstr[20:16]);

	always_comb begin
		idHaz.rs = ifIdInstr[25:21];
		idHaz.rt = storeAfterLoad ? '0 : ifIdInstr[20:16];
		idHaz.branch = ifIdValid && (opcode == opBeq);
	end

	// No internal bypass in the register file
	assign idRsVal = fwd.writeToRead[0] ? memWb.result : rdDataA;
	assign idRtVal = fwd.writeToRead[1] ? memWb.result : rdDataB;
	assign brA = fwd.forwardC ? exMem.aluOut : idRsVal;
	assign brB = fwd.forwardD ? exMem.aluOut : idRtVal;
	// Operands are stale while stalled
	assign taken = idHaz.branch && (brA == brB) && !fwd.stall;

	always_comb begin
		dec = '0;
		if (ifIdValid) begin
			dec.rs = ifIdInstr[25:21];
			dec.rt = ifIdInstr[20:16];
			dec.rsVal = idRsVal;
			dec.rtVal = idRtVal;
			dec.imm = immExt;
			case (opcode)
				opRtype: begin
					dec.regWrite = 1'b1;
					dec.aluSub = (funct == fnSub);
					// Other functions, the zero word too, land in r0
					dec.rd = ((funct == fnAdd) || (funct == fnSub)) ? ifIdInstr[15:11] : '0;
				end
				opAddi: begin
					dec.regWrite = 1'b1;
					dec.aluImm = 1'b1;
					dec.rd = ifIdInstr[20:16];
				end
				opLw: begin
					dec.memRead = 1'b1;
					dec.memToReg = 1'b1;
					dec.aluImm = 1'b1;
				end
				opSw: begin
					dec.memWrite = 1'b1;
					dec.aluImm = 1'b1;
				end
				// BEQ finishes here
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset || fwd.stall) begin
			idEx <= '0;
		end else begin
			idEx <= dec;
		end
	end

endmodule

`default_nettype wire

//--- src/executeMemory.sv
`timescale 1ns/100ps
`default_nettype none

module executeMemory #(
	parameter int dmemWords = 64
) (
	input logic clk,
	input logic reset,
	input pipeCpuPkg::idExT idEx,
	input pipeCpuPkg::fwdCtrlT fwd,
	output pipeCpuPkg::exMemT exMem,
	output pipeCpuPkg::memWbT memWb,
	output logic wrEn,
	output pipeCpuPkg::regAddrT wrAddr,
	output pipeCpuPkg::wordT wrData,
	output logic storeValid,
	output pipeCpuPkg::wordT storeAddr,
	output pipeCpuPkg::wordT storeData,
	output logic wbValid,
	output pipeCpuPkg::regAddrT wbReg,
	output pipeCpuPkg::wordT wbData
);
	import pipeCpuPkg::*;

	localparam int dIdxW = $clog2(dmemWords);

	// Word-addressed data memory
	wordT dmem [dmemWords];
	// EX operands after forwarding
	wordT opA;
	wordT opB;
	wordT aluB;
	wordT aluOut;
	// MEM side
	logic [dIdxW-1:0] memIdx;
	wordT loadData;
	wordT storeSel;

	// Register value, MEM/WB or EX/MEM
	function automatic wordT pickOperand(input fwdSelT sel, input wordT regVal,
			input wordT exVal, input wordT wbVal);
		case (sel)
			fwdExMem: return exVal;
			fwdMemWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwd.forwardA, idEx.rsVal, exMem.aluOut, memWb.result);
	assign opB = pickOperand(fwd.forwardB, idEx.rtVal, exMem.aluOut, memWb.result);
	// Loads and stores use rs plus imm
	assign aluB = idEx.aluImm ? idEx.imm : opB;
	assign aluOut = idEx.aluSub ? (opA - aluB) : (opA + aluB);

	// EX/MEM
	always_ff @(posedge clk) begin
		if (reset) begin
			exMem <= '0;
		end else begin
			exMem.regWrite <= idEx.regWrite;
			exMem.memToReg <= idEx.memToReg;
			exMem.memWrite <= idEx.memWrite;
			exMem.rs <= idEx.rs;
			exMem.rt <= idEx.rt;
			exMem.rd <= idEx.rd;
			exMem.aluOut <= aluOut;
			// Forwarded rt is the store data
			exMem.storeVal <= opB;
		end
	end

	assign memIdx = exMem.aluOut[dIdxW+1:2];
	assign loadData = dmem[memIdx];
	// Loaded word copied straight into a following store
	assign storeSel = fwd.memToMem ? memWb.result : exMem.storeVal;

	always_ff @(posedge clk) begin
		if (exMem.memWrite) begin
			dmem[memIdx] <= storeSel;
		end
	end

	// MEM/WB
	always_ff @(posedge clk) begin
		if (reset) begin
			memWb <= '0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.rt <= exMem.rt;
			memWb.rd <= exMem.rd;
			memWb.result <= exMem.memToReg ? loadData : exMem.aluOut;
		end
	end

	assign storeValid = exMem.memWrite;
	assign storeAddr = exMem.aluOut;
	assign storeData = storeSel;

	// Loads write rt, ALU ops write rd
	assign wrEn = memWb.regWrite || memWb.memToReg;
	assign wrAddr = memWb.memToReg ? memWb.rt : memWb.rd;
	assign wrData = memWb.result;

	// Retirement strobe
	assign wbValid = wrEn;
	assign wbReg = wrAddr;
	assign wbData = wrData;

endmodule

`default_nettype wire

//--- src/pipeCpu.sv
`timescale 1ns/100ps
`default_nettype none

module pipeCpu #(
	parameter int imemWords = 64,
	parameter int dmemWords = 64
) (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input logic [$clog2(imemWords)-1:0] progAddr,
	input pipeCpuPkg::wordT progData,
	output logic wbValid,
	output pipeCpuPkg::regAddrT wbReg,
	output pipeCpuPkg::wordT wbData,
	output logic storeValid,
	output pipeCpuPkg::wordT storeAddr,
	output pipeCpuPkg::wordT storeData
);
	import pipeCpuPkg::*;

	// Stage records
	idHazT idHaz;
	idExT idEx;
	exMemT exMem;
	memWbT memWb;
	fwdCtrlT fwd;
	// Register file ports
	regAddrT rdAddrA;
	regAddrT rdAddrB;
	wordT rdDataA;
	wordT rdDataB;
	logic wrEn;
	regAddrT wrAddr;
	wordT wrData;

	fetchDecode #(
		.imemWords(imemWords)
	) fetch (
		.clk(clk),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.fwd(fwd),
		.exMem(exMem),
		.memWb(memWb),
		.idHaz(idHaz),
		.idEx(idEx),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	registerFile regs (
		.clk(clk),
		.reset(reset),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	executeMemory #(
		.dmemWords(dmemWords)
	) execute (
		.clk(clk),
		.reset(reset),
		.idEx(idEx),
		.fwd(fwd),
		.exMem(exMem),
		.memWb(memWb),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	hazardUnit hazard (
		.idHaz(idHaz),
		.idEx(idEx),
		.exMem(exMem),
		.memWb(memWb),
		.fwd(fwd)
	);

endmodule

`default_nettype wire

//--- sim/pipeCpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module pipeCpuTb;

	localparam int imemWords = 64;
	localparam int dmemWords = 64;
	// Instruction encodings
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;

	// One expected retirement write or data-memory store
	typedef struct packed {
		logic isStore;
		logic [31:0] where;
		logic [31:0] value;
	} eventT;

	logic clk;
	logic reset;
	logic progWrite;
	logic [$clog2(imemWords)-1:0] progAddr;
	logic [31:0] progData;
	logic wbValid;
	logic [4:0] wbReg;
	logic [31:0] wbData;
	logic storeValid;
	logic [31:0] storeAddr;
	logic [31:0] storeData;

	// Program words and expected events, in program order
	logic [31:0] prog [$];
	eventT events [$];
	int eventIdx = 0;
	int passCount = 0;
	int failCount = 0;
	int cycles = 0;
	int cycleLimit = 0;

	pipeCpu #(
		.imemWords(imemWords),
		.dmemWords(dmemWords)
	) UUT (
		.clk(clk),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.storeValid(storeValid),
		.storeAddr(storeAddr),
		.storeData(storeData)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	task automatic addEvent(input logic isStore, input logic [31:0] where,
			input logic [31:0] value);
		eventT e;
		e.isStore = isStore;
		e.where = where;
		e.value = value;
		events.push_back(e);
	endtask

	// Expected values follow plain sequential execution
	task automatic buildTable();
		// ALU chain through EX/MEM and MEM/WB
		prog.push_back(iType(opAddi, 5'd0, 5'd1, 16'd5));
		addEvent(1'b0, 32'd1, 32'd5);
		prog.push_back(iType(opAddi, 5'd0, 5'd2, 16'd12));
		addEvent(1'b0, 32'd2, 32'd12);
		prog.push_back(rType(fnAdd, 5'd1, 5'd2, 5'd3));
		addEvent(1'b0, 32'd3, 32'd17);
		// r1 is read in ID while it writes back
		prog.push_back(rType(fnSub, 5'd3, 5'd1, 5'd4));
		addEvent(1'b0, 32'd4, 32'd12);
		prog.push_back(iType(opAddi, 5'd4, 5'd5, 16'd100));
		addEvent(1'b0, 32'd5, 32'd112);
		prog.push_back(rType(fnAdd, 5'd3, 5'd4, 5'd6));
		addEvent(1'b0, 32'd6, 32'd29);
		// Seed data memory for the loads
		prog.push_back(iType(opSw, 5'd0, 5'd5, 16'd0));
		addEvent(1'b1, 32'd0, 32'd112);
		prog.push_back(iType(opSw, 5'd0, 5'd6, 16'd4));
		addEvent(1'b1, 32'd4, 32'd29);
		// Load then use
		prog.push_back(iType(opLw, 5'd0, 5'd7, 16'd0));
		addEvent(1'b0, 32'd7, 32'd112);
		prog.push_back(rType(fnAdd, 5'd7, 5'd1, 5'd8));
		addEvent(1'b0, 32'd8, 32'd117);
		// Load then store of the same register
		prog.push_back(iType(opLw, 5'd0, 5'd9, 16'd4));
		addEvent(1'b0, 32'd9, 32'd29);
		prog.push_back(iType(opSw, 5'd0, 5'd9, 16'd8));
		addEvent(1'b1, 32'd8, 32'd29);
		prog.push_back(iType(opLw, 5'd0, 5'd10, 16'd8));
		addEvent(1'b0, 32'd10, 32'd29);
		// Branch on the ADD right before it, skips one slot
		prog.push_back(iType(opAddi, 5'd0, 5'd12, 16'd10));
		addEvent(1'b0, 32'd12, 32'd10);
		prog.push_back(rType(fnAdd, 5'd1, 5'd1, 5'd11));
		addEvent(1'b0, 32'd11, 32'd10);
		prog.push_back(iType(opBeq, 5'd11, 5'd12, 16'd1));
		// Squashed, must never retire
		prog.push_back(iType(opAddi, 5'd0, 5'd13, 16'd99));
		prog.push_back(iType(opAddi, 5'd0, 5'd13, 16'd7));
		addEvent(1'b0, 32'd13, 32'd7);
		// Write to r0, later readers still see zero
		prog.push_back(iType(opAddi, 5'd0, 5'd0, 16'd55));
		prog.push_back(rType(fnAdd, 5'd0, 5'd13, 5'd14));
		addEvent(1'b0, 32'd14, 32'd7);
		prog.push_back(iType(opAddi, 5'd0, 5'd15, 16'd3));
		addEvent(1'b0, 32'd15, 32'd3);
		// Branch to itself holds the PC here
		prog.push_back(iType(opBeq, 5'd0, 5'd0, 16'hffff));
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected, output logic ok);
		ok = (got === expected);
		if (!ok) begin
			$display("** Error: %s = %h, expected %h", name, got, expected);
		end
	endtask

	// Compare one DUT event with the next table row
	task automatic takeEvent(input logic isStore, input logic [31:0] where,
			input logic [31:0] value);
		eventT exp;
		logic okWhere;
		logic okValue;
		string kind;
		string whereName;
		string valueName;
		if (isStore) begin
			kind = "store";
			whereName = "storeAddr";
			valueName = "storeData";
		end else begin
			kind = "write";
			whereName = "wbReg";
			valueName = "wbData";
		end
		if (eventIdx >= events.size()) begin
			$display("Unexpected %s to %h with %h after the last expected event",
				kind, where, value);
			failCount++;
			return;
		end
		exp = events[eventIdx];
		eventIdx++;
		if (exp.isStore != isStore) begin
			$display("Test %0d: the DUT made a %s where the program order needs the other kind",
				eventIdx, kind);
			failCount++;
			return;
		end
		checkValue(whereName, where, exp.where, okWhere);
		checkValue(valueName, value, exp.value, okValue);
		if (okWhere && okValue) begin
			passCount++;
			$display("Test %0d: %s %h = %h passed", eventIdx, kind, where, value);
		end else begin
			failCount++;
			$display("Test %0d: %s failed", eventIdx, kind);
		end
	endtask

	// Mid-cycle sampling, older writeback before the store in MEM
	always @(negedge clk) begin
		if (!reset) begin
			if (wbValid && (wbReg != 5'd0)) begin
				takeEvent(1'b0, {27'd0, wbReg}, wbData);
			end
			if (storeValid) begin
				takeEvent(1'b1, storeAddr, storeData);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if ((cycleLimit > 0) && (cycles >= cycleLimit)) begin
			$display("Timeout after %0d cycles, only %0d of %0d events seen",
				cycles, eventIdx, events.size());
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		buildTable();
		cycleLimit = 5 * (prog.size() + events.size()) + 50;
		// Unused words are r0 no-ops tagged with their address
		for (int i = 0; i < imemWords; i++) begin
			@(posedge clk);
			#10;
			progWrite = 1'b1;
			progAddr = i[5:0];
			progData = (i < prog.size()) ? prog[i] : iType(opAddi, 5'd0, 5'd0, i[15:0]);
		end
		@(posedge clk);
		#10;
		progWrite = 1'b0;
		// Reset stays high through the load and 10 cycles more
		repeat (10) @(posedge clk);
		#10;
		reset = 1'b0;
		wait (eventIdx == events.size());
		// Extra cycles catch stray retirements
		repeat (10) @(posedge clk);
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if ((failCount == 0) && (passCount == events.size())) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- pipeCpu.f
src/pipeCpuPkg.sv
src/hazardUnit.sv
src/registerFile.sv
src/fetchDecode.sv
src/executeMemory.sv
src/pipeCpu.sv
sim/pipeCpuTb.sv

//--- run.sh
#!/bin/sh
# Compile the pipeline and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module pipeCpuTb -f pipeCpu.f -o pipeCpuSim
./obj_dir/pipeCpuSim > sim.log
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
exit 0
